// File: compile.f
logic/soc_map_pkg.sv
logic/bus_pkg.sv
logic/mem_bus_if.sv
logic/addr_decoder.sv
logic/bus_router.sv
logic/apb_bridge.sv
logic/soc_interconnect.sv
bench/tb_targets.sv
bench/tb_soc_interconnect.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_soc_interconnect -f compile.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep "All checks passed" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: bench/tb_soc_interconnect.sv
// -------------------------------------------------------------------------
// Testbench for the SoC interconnect with random traffic over the whole map
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_soc_interconnect;

   localparam int N_TRANS          = 300;
   localparam int CYCLES_PER_TRANS = 40;
   localparam int CLK_PERIOD       = 8;
   localparam int RESET_CYCLES     = 5;
   localparam int WATCHDOG_NS      = N_TRANS * CYCLES_PER_TRANS * CLK_PERIOD;

   logic               clk;
   logic               reset_i = 1'b1;
   logic               req_valid_i = 1'b0;
   logic               req_write_i = 1'b0;
   bus_pkg::addr_t     req_addr_i = '0;
   bus_pkg::data_t     req_wdata_i = '0;
   bus_pkg::strb_t     req_wstrb_i = '0;
   logic               rsp_ready_i = 1'b0;
   logic               req_ready_o, rsp_valid_o, rsp_err_o;
   bus_pkg::data_t     rsp_rdata_o;
   logic               mem_write_o;
   bus_pkg::addr_t     mem_addr_o;
   bus_pkg::data_t     mem_wdata_o;
   bus_pkg::strb_t     mem_wstrb_o;
   logic               rom_req_valid_o, rom_req_ready_i, rom_rsp_valid_i;
   logic               rom_rsp_ready_o, rom_rsp_err_i;
   bus_pkg::data_t     rom_rsp_rdata_i;
   logic               clint_req_valid_o, clint_req_ready_i, clint_rsp_valid_i;
   logic               clint_rsp_ready_o, clint_rsp_err_i;
   bus_pkg::data_t     clint_rsp_rdata_i;
   logic               slm_req_valid_o, slm_req_ready_i, slm_rsp_valid_i;
   logic               slm_rsp_ready_o, slm_rsp_err_i;
   bus_pkg::data_t     slm_rsp_rdata_i;
   logic               dram_req_valid_o, dram_req_ready_i, dram_rsp_valid_i;
   logic               dram_rsp_ready_o, dram_rsp_err_i;
   bus_pkg::data_t     dram_rsp_rdata_i;
   logic               psel_o, penable_o, pwrite_o, pready_i, pslverr_i;
   bus_pkg::apb_addr_t paddr_o;
   bus_pkg::apb_data_t pwdata_o, prdata_i;

   // Scoreboard for the one transaction in flight
   logic                 in_flight = 1'b0;
   bus_pkg::addr_t       cur_addr;
   bus_pkg::data_t       cur_wdata;
   logic                 cur_write;
   soc_map_pkg::target_e cur_tgt;
   soc_map_pkg::target_e exp_tgt;
   logic [3:0]           mem_valids;
   logic [3:0]           exp_valids;
   logic [3:0]           mem_rsp_readys;
   logic [3:0]           exp_rsp_readys;
   int                   value_errors = 0;
   int                   proto_errors = 0;
   int                   completed = 0;

   function automatic soc_map_pkg::target_e region_of(input bus_pkg::addr_t a);
      if (a - soc_map_pkg::ROM_BASE < soc_map_pkg::ROM_LENGTH) return soc_map_pkg::TGT_ROM;
      if (a - soc_map_pkg::APB_BASE < soc_map_pkg::APB_LENGTH) return soc_map_pkg::TGT_APB;
      if (a - soc_map_pkg::CLINT_BASE < soc_map_pkg::CLINT_LENGTH) return soc_map_pkg::TGT_CLINT;
      if (a - soc_map_pkg::SLM_BASE < soc_map_pkg::SLM_LENGTH) return soc_map_pkg::TGT_SLM;
      if (a - soc_map_pkg::DRAM_BASE < soc_map_pkg::DRAM_LENGTH) return soc_map_pkg::TGT_DRAM;
      return soc_map_pkg::TGT_NONE;
   endfunction

   function automatic bus_pkg::data_t tag_of(input soc_map_pkg::target_e t);
      case (t)
         soc_map_pkg::TGT_ROM:   return 64'hA5A5_0000_0000_0001;
         soc_map_pkg::TGT_CLINT: return 64'h5A5A_0000_0000_0002;
         soc_map_pkg::TGT_SLM:   return 64'h0F0F_0000_0000_0003;
         soc_map_pkg::TGT_DRAM:  return 64'hF0F0_0000_0000_0004;
         default:                return '0;
      endcase
   endfunction

   // Bit of a memory target in the four-bit target vectors
   function automatic logic [3:0] mem_mask(input soc_map_pkg::target_e t);
      case (t)
         soc_map_pkg::TGT_ROM:   return 4'b0001;
         soc_map_pkg::TGT_CLINT: return 4'b0010;
         soc_map_pkg::TGT_SLM:   return 4'b0100;
         soc_map_pkg::TGT_DRAM:  return 4'b1000;
         default:                return 4'b0000;
      endcase
   endfunction

   function automatic bus_pkg::data_t expected_rdata(input soc_map_pkg::target_e t,
                                                     input bus_pkg::addr_t a);
      if (t == soc_map_pkg::TGT_NONE) return '0;
      if (t == soc_map_pkg::TGT_APB) return {~a[31:0], ~a[31:0]};
      return a ^ tag_of(t);
   endfunction

   function automatic bus_pkg::addr_t random_addr();
      bus_pkg::addr_t ofs;
      ofs = 64'($urandom);
      case ($urandom_range(0, 7))
         0: return soc_map_pkg::ROM_BASE + ofs % soc_map_pkg::ROM_LENGTH;
         1: return soc_map_pkg::APB_BASE + ofs % soc_map_pkg::APB_LENGTH;
         2: return soc_map_pkg::CLINT_BASE + ofs % soc_map_pkg::CLINT_LENGTH;
         3: return soc_map_pkg::SLM_BASE + ofs % soc_map_pkg::SLM_LENGTH;
         4: return soc_map_pkg::DRAM_BASE + ofs % soc_map_pkg::DRAM_LENGTH;
         // Unmapped gaps below ROM, between APB and DRAM and above 4 GiB
         5: return ofs % 64'h1_0000;
         6: return 64'h7000_0000 + ofs % 64'h1000_0000;
         default: return {$urandom | 32'h1, ofs[31:0]};
      endcase
   endfunction

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      assert (actual === expected) else begin
         value_errors++;
         $display("[ERROR] %s expected %h actual %h", name, expected, actual);
      end
   endtask

   soc_interconnect DUT (.*);

   tb_mem_target u_rom (.clk, .reset_i, .req_valid_i (rom_req_valid_o),
      .req_ready_o (rom_req_ready_i), .addr_i (mem_addr_o), .tag_i (tag_of(soc_map_pkg::TGT_ROM)),
      .rsp_valid_o (rom_rsp_valid_i), .rsp_ready_i (rom_rsp_ready_o),
      .rsp_rdata_o (rom_rsp_rdata_i), .rsp_err_o (rom_rsp_err_i));
   tb_mem_target u_clint (.clk, .reset_i, .req_valid_i (clint_req_valid_o),
      .req_ready_o (clint_req_ready_i), .addr_i (mem_addr_o),
      .tag_i (tag_of(soc_map_pkg::TGT_CLINT)), .rsp_valid_o (clint_rsp_valid_i),
      .rsp_ready_i (clint_rsp_ready_o), .rsp_rdata_o (clint_rsp_rdata_i),
      .rsp_err_o (clint_rsp_err_i));
   tb_mem_target u_slm (.clk, .reset_i, .req_valid_i (slm_req_valid_o),
      .req_ready_o (slm_req_ready_i), .addr_i (mem_addr_o), .tag_i (tag_of(soc_map_pkg::TGT_SLM)),
      .rsp_valid_o (slm_rsp_valid_i), .rsp_ready_i (slm_rsp_ready_o),
      .rsp_rdata_o (slm_rsp_rdata_i), .rsp_err_o (slm_rsp_err_i));
   tb_mem_target u_dram (.clk, .reset_i, .req_valid_i (dram_req_valid_o),
      .req_ready_o (dram_req_ready_i), .addr_i (mem_addr_o),
      .tag_i (tag_of(soc_map_pkg::TGT_DRAM)), .rsp_valid_o (dram_rsp_valid_i),
      .rsp_ready_i (dram_rsp_ready_o), .rsp_rdata_o (dram_rsp_rdata_i),
      .rsp_err_o (dram_rsp_err_i));
   tb_apb_slave u_apb (.clk, .reset_i, .psel_i (psel_o), .penable_i (penable_o),
      .paddr_i (paddr_o), .prdata_o (prdata_i), .pready_o (pready_i), .pslverr_o (pslverr_i));

   assign mem_valids = {dram_req_valid_o, slm_req_valid_o, clint_req_valid_o, rom_req_valid_o};
   assign mem_rsp_readys = {dram_rsp_ready_o, slm_rsp_ready_o, clint_rsp_ready_o,
                            rom_rsp_ready_o};
   assign exp_tgt    = region_of(req_addr_i);
   assign exp_valids = (req_valid_i && !in_flight) ? mem_mask(exp_tgt) : 4'b0;
   // Back-pressure reaches only the target that owns the response
   assign exp_rsp_readys = (in_flight && rsp_ready_i) ? mem_mask(cur_tgt) : 4'b0;

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      rsp_ready_i <= ($urandom_range(0, 2) != 0);
   end

   // -------------------------------------------------------------------------
   // Per-cycle checks and scoreboard
   // -------------------------------------------------------------------------
   always @(posedge clk) begin
      if (reset_i) begin
         in_flight <= 1'b0;
      end else begin
         check_value("target_valid", 64'(exp_valids), 64'(mem_valids));
         check_value("target_rsp_ready", 64'(exp_rsp_readys), 64'(mem_rsp_readys));
         if (!(in_flight && cur_tgt == soc_map_pkg::TGT_APB)) begin
            check_value("psel_idle", 64'h0, 64'(psel_o));
         end
         if (!in_flight) begin
            check_value("rsp_valid_idle", 64'h0, 64'(rsp_valid_o));
         end
         if (req_valid_i && !in_flight) begin
            check_value("mem_addr", req_addr_i, mem_addr_o);
            check_value("mem_write", 64'(req_write_i), 64'(mem_write_o));
            check_value("mem_wdata", req_wdata_i, mem_wdata_o);
            check_value("mem_wstrb", 64'(req_wstrb_i), 64'(mem_wstrb_o));
            if (req_ready_o) begin
               in_flight <= 1'b1;
               cur_addr  <= req_addr_i;
               cur_wdata <= req_wdata_i;
               cur_write <= req_write_i;
               cur_tgt   <= exp_tgt;
            end
         end
         if (psel_o && !penable_o) begin
            check_value("apb_paddr", 64'(cur_addr[31:0]), 64'(paddr_o));
            check_value("apb_pwrite", 64'(cur_write), 64'(pwrite_o));
            check_value("apb_pwdata",
                        64'(cur_addr[2] ? cur_wdata[63:32] : cur_wdata[31:0]), 64'(pwdata_o));
         end
         if (in_flight && rsp_valid_o && rsp_ready_i) begin
            check_value("rsp_rdata", expected_rdata(cur_tgt, cur_addr), rsp_rdata_o);
            check_value("rsp_err", 64'((cur_tgt == soc_map_pkg::TGT_NONE) ||
                        (cur_tgt == soc_map_pkg::TGT_APB && cur_addr[3])), 64'(rsp_err_o));
            completed++;
            in_flight <= 1'b0;
         end
      end
   end

   p_apb_setup: assert property (@(posedge clk) disable iff (reset_i)
      (req_valid_i && req_ready_o && !in_flight && exp_tgt == soc_map_pkg::TGT_APB)
      |=> psel_o && !penable_o)
      else begin
         proto_errors++;
         $display("APB setup phase did not follow an accepted request");
      end

   p_apb_access: assert property (@(posedge clk) disable iff (reset_i)
      (psel_o && !penable_o) |=> psel_o && penable_o)
      else begin
         proto_errors++;
         $display("APB access phase did not follow the setup phase");
      end

   p_apb_hold: assert property (@(posedge clk) disable iff (reset_i)
      penable_o |-> $stable(paddr_o) && $stable(pwrite_o) && $stable(pwdata_o))
      else begin
         proto_errors++;
         $display("APB address or control changed during the access phase");
      end

   p_rsp_hold: assert property (@(posedge clk) disable iff (reset_i)
      (rsp_valid_o && !rsp_ready_i) |=>
      rsp_valid_o && $stable(rsp_rdata_o) && $stable(rsp_err_o))
      else begin
         proto_errors++;
         $display("Response changed while rsp_ready_i was low");
      end

   p_busy: assert property (@(posedge clk) disable iff (reset_i)
      in_flight |-> !req_ready_o)
      else begin
         proto_errors++;
         $display("Request accepted while a transaction was outstanding");
      end

   // -------------------------------------------------------------------------
   // Stimulus
   // -------------------------------------------------------------------------
   initial begin
      void'($urandom(81));
      repeat (RESET_CYCLES) @(posedge clk);
      check_value("reset_rsp_valid", 64'h0, 64'(rsp_valid_o));
      check_value("reset_mem_valid", 64'h0, 64'(mem_valids));
      check_value("reset_psel", 64'h0, 64'(psel_o));
      check_value("reset_penable", 64'h0, 64'(penable_o));
      reset_i <= 1'b0;
      for (int n = 0; n < N_TRANS; n++) begin
         req_valid_i <= 1'b1;
         req_write_i <= 1'($urandom_range(0, 1));
         req_addr_i  <= random_addr();
         req_wdata_i <= {$urandom, $urandom};
         req_wstrb_i <= 8'($urandom);
         do @(posedge clk); while (!req_ready_o);
         req_valid_i <= 1'b0;
         do @(posedge clk); while (!(rsp_valid_o && rsp_ready_i));
      end
      repeat (2) @(posedge clk);
      $display("Transactions %0d of %0d, value errors %0d, protocol errors %0d",
               completed, N_TRANS, value_errors, proto_errors);
      if (value_errors == 0 && proto_errors == 0 && completed == N_TRANS) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired, %0d of %0d transactions completed", completed, N_TRANS);
      $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: bench/tb_targets.sv
// -------------------------------------------------------------------------
// Target models, memory responder and APB slave with random stalls
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_mem_target (
   input  logic           clk,
   input  logic           reset_i,
   input  logic           req_valid_i,
   output logic           req_ready_o,
   input  bus_pkg::addr_t addr_i,
   input  bus_pkg::data_t tag_i,
   output logic           rsp_valid_o,
   input  logic           rsp_ready_i,
   output bus_pkg::data_t rsp_rdata_o,
   output logic           rsp_err_o
);

   logic           busy = 1'b0;
   logic           ready_q = 1'b0;
   logic           valid_q = 1'b0;
   bus_pkg::data_t rdata_q = '0;
   logic [2:0]     stall = '0;

   assign req_ready_o = ready_q;
   assign rsp_valid_o = valid_q;
   assign rsp_rdata_o = rdata_q;
   assign rsp_err_o   = 1'b0;

   always @(posedge clk) begin
      if (reset_i) begin
         busy    <= 1'b0;
         ready_q <= 1'b0;
         valid_q <= 1'b0;
      end else if (!busy) begin
         if (req_valid_i && ready_q) begin
            busy    <= 1'b1;
            ready_q <= 1'b0;
            rdata_q <= addr_i ^ tag_i;
            stall   <= 3'($urandom_range(0, 4));
         end else begin
            // Ready wanders even with no request pending
            ready_q <= ($urandom_range(0, 3) != 0);
         end
      end else if (valid_q) begin
         if (rsp_ready_i) begin
            valid_q <= 1'b0;
            busy    <= 1'b0;
         end
      end else if (stall == 3'd0) begin
         valid_q <= 1'b1;
      end else begin
         stall <= stall - 3'd1;
      end
   end

endmodule

module tb_apb_slave (
   input  logic               clk,
   input  logic               reset_i,
   input  logic               psel_i,
   input  logic               penable_i,
   input  bus_pkg::apb_addr_t paddr_i,
   output bus_pkg::apb_data_t prdata_o,
   output logic               pready_o,
   output logic               pslverr_o
);

   logic               ready_q = 1'b0;
   bus_pkg::apb_data_t rdata_q = '0;
   logic               err_q = 1'b0;
   logic [1:0]         wait_q = '0;

   assign pready_o  = ready_q;
   assign prdata_o  = rdata_q;
   assign pslverr_o = err_q;

   always @(posedge clk) begin
      if (reset_i) begin
         ready_q <= 1'b0;
      end else if (psel_i && !penable_i) begin
         wait_q  <= 2'($urandom_range(0, 3));
         ready_q <= 1'b0;
      end else if (psel_i && penable_i && !ready_q) begin
         if (wait_q == 2'd0) begin
            ready_q <= 1'b1;
            rdata_q <= ~paddr_i;
            err_q   <= paddr_i[3];
         end else begin
            wait_q <= wait_q - 2'd1;
         end
      end else begin
         ready_q <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: logic/soc_interconnect.sv
// -------------------------------------------------------------------------
// SoC interconnect, one request port to four memory targets and APB
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module soc_interconnect (
   input  logic               clk,
   input  logic               reset_i,
   // Request
   input  logic               req_valid_i,
   output logic               req_ready_o,
   input  logic               req_write_i,
   input  bus_pkg::addr_t     req_addr_i,
   input  bus_pkg::data_t     req_wdata_i,
   input  bus_pkg::strb_t     req_wstrb_i,
   // Response
   output logic               rsp_valid_o,
   input  logic               rsp_ready_i,
   output bus_pkg::data_t     rsp_rdata_o,
   output logic               rsp_err_o,
   // Shared memory payload
   output logic               mem_write_o,
   output bus_pkg::addr_t     mem_addr_o,
   output bus_pkg::data_t     mem_wdata_o,
   output bus_pkg::strb_t     mem_wstrb_o,
   // ROM
   output logic               rom_req_valid_o,
   input  logic               rom_req_ready_i,
   input  logic               rom_rsp_valid_i,
   output logic               rom_rsp_ready_o,
   input  bus_pkg::data_t     rom_rsp_rdata_i,
   input  logic               rom_rsp_err_i,
   // CLINT
   output logic               clint_req_valid_o,
   input  logic               clint_req_ready_i,
   input  logic               clint_rsp_valid_i,
   output logic               clint_rsp_ready_o,
   input  bus_pkg::data_t     clint_rsp_rdata_i,
   input  logic               clint_rsp_err_i,
   // SLM
   output logic               slm_req_valid_o,
   input  logic               slm_req_ready_i,
   input  logic               slm_rsp_valid_i,
   output logic               slm_rsp_ready_o,
   input  bus_pkg::data_t     slm_rsp_rdata_i,
   input  logic               slm_rsp_err_i,
   // DRAM
   output logic               dram_req_valid_o,
   input  logic               dram_req_ready_i,
   input  logic               dram_rsp_valid_i,
   output logic               dram_rsp_ready_o,
   input  bus_pkg::data_t     dram_rsp_rdata_i,
   input  logic               dram_rsp_err_i,
   // APB
   output logic               psel_o,
   output logic               penable_o,
   output logic               pwrite_o,
   output bus_pkg::apb_addr_t paddr_o,
   output bus_pkg::apb_data_t pwdata_o,
   input  bus_pkg::apb_data_t prdata_i,
   input  logic               pready_i,
   input  logic               pslverr_i
);

   mem_bus_if apb_bus ();

   // Port names match one to one
   bus_router u_router (
      .*
   );

   apb_bridge u_apb_bridge (
      .*,
      .bus (apb_bus)
   );

endmodule

`default_nettype wire

// File: logic/apb_bridge.sv
// -------------------------------------------------------------------------
// Bridge from the 64-bit request bus to a 32-bit APB port
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module apb_bridge (
   input  logic               clk,
   input  logic               reset_i,
   mem_bus_if.target          bus,
   output logic               psel_o,
   output logic               penable_o,
   output logic               pwrite_o,
   output bus_pkg::apb_addr_t paddr_o,
   output bus_pkg::apb_data_t pwdata_o,
   input  bus_pkg::apb_data_t prdata_i,
   input  logic               pready_i,
   input  logic               pslverr_i
);

   bus_pkg::apb_state_e state_q;

   // Request and response payload
   logic               write_q;
   bus_pkg::apb_addr_t addr_q;
   bus_pkg::apb_data_t wdata_q;
   bus_pkg::apb_data_t rdata_q;
   logic               err_q;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q <= bus_pkg::APB_IDLE;
      end else begin
         case (state_q)
            bus_pkg::APB_IDLE: begin
               if (bus.req_valid) begin
                  state_q <= bus_pkg::APB_SETUP;
               end
            end
            bus_pkg::APB_SETUP: begin
               state_q <= bus_pkg::APB_ACCESS;
            end
            bus_pkg::APB_ACCESS: begin
               if (pready_i) begin
                  state_q <= bus_pkg::APB_RESP;
               end
            end
            default: begin
               if (bus.rsp_ready) begin
                  state_q <= bus_pkg::APB_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == bus_pkg::APB_IDLE && bus.req_valid) begin
         write_q <= bus.req_write;
         addr_q  <= bus.req_addr[bus_pkg::APB_ADDR_WIDTH-1:0];
         // Address bit 2 picks the 32-bit lane
         wdata_q <= bus.req_addr[2] ? bus.req_wdata[63:32] : bus.req_wdata[31:0];
      end
      if (state_q == bus_pkg::APB_ACCESS && pready_i) begin
         rdata_q <= prdata_i;
         err_q   <= pslverr_i;
      end
   end

   assign bus.req_ready = (state_q == bus_pkg::APB_IDLE);
   assign bus.rsp_valid = (state_q == bus_pkg::APB_RESP);
   assign bus.rsp_rdata = {rdata_q, rdata_q};
   assign bus.rsp_err   = err_q;

   assign psel_o    = (state_q == bus_pkg::APB_SETUP) || (state_q == bus_pkg::APB_ACCESS);
   assign penable_o = (state_q == bus_pkg::APB_ACCESS);
   assign pwrite_o  = write_q;
   assign paddr_o   = addr_q;
   assign pwdata_o  = wdata_q;

   // Access phase always comes after a setup cycle with psel held
   a_enable_after_setup: assert property (@(posedge clk) disable iff (reset_i)
      penable_o |-> psel_o && $past(psel_o));

   a_stable_ctrl: assert property (@(posedge clk) disable iff (reset_i)
      penable_o |-> $stable(paddr_o) && $stable(pwrite_o));

endmodule

`default_nettype wire

// File: logic/bus_router.sv
// -------------------------------------------------------------------------
// Request router to the memory targets and the APB bridge, one
// transaction outstanding, decode errors for unmapped addresses
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bus_router (
   input  logic            clk,
   input  logic            reset_i,
   // Request from the initiator
   input  logic            req_valid_i,
   output logic            req_ready_o,
   input  logic            req_write_i,
   input  bus_pkg::addr_t  req_addr_i,
   input  bus_pkg::data_t  req_wdata_i,
   input  bus_pkg::strb_t  req_wstrb_i,
   // Response to the initiator
   output logic            rsp_valid_o,
   input  logic            rsp_ready_i,
   output bus_pkg::data_t  rsp_rdata_o,
   output logic            rsp_err_o,
   // Shared memory payload
   output logic            mem_write_o,
   output bus_pkg::addr_t  mem_addr_o,
   output bus_pkg::data_t  mem_wdata_o,
   output bus_pkg::strb_t  mem_wstrb_o,
   // ROM
   output logic            rom_req_valid_o,
   input  logic            rom_req_ready_i,
   input  logic            rom_rsp_valid_i,
   output logic            rom_rsp_ready_o,
   input  bus_pkg::data_t  rom_rsp_rdata_i,
   input  logic            rom_rsp_err_i,
   // CLINT
   output logic            clint_req_valid_o,
   input  logic            clint_req_ready_i,
   input  logic            clint_rsp_valid_i,
   output logic            clint_rsp_ready_o,
   input  bus_pkg::data_t  clint_rsp_rdata_i,
   input  logic            clint_rsp_err_i,
   // SLM
   output logic            slm_req_valid_o,
   input  logic            slm_req_ready_i,
   input  logic            slm_rsp_valid_i,
   output logic            slm_rsp_ready_o,
   input  bus_pkg::data_t  slm_rsp_rdata_i,
   input  logic            slm_rsp_err_i,
   // DRAM
   output logic            dram_req_valid_o,
   input  logic            dram_req_ready_i,
   input  logic            dram_rsp_valid_i,
   output logic            dram_rsp_ready_o,
   input  bus_pkg::data_t  dram_rsp_rdata_i,
   input  logic            dram_rsp_err_i,
   // APB bridge
   mem_bus_if.initiator    apb_bus
);

   localparam int unsigned NT = soc_map_pkg::N_TARGETS;

   bus_pkg::route_state_e state_q, state_d;
   soc_map_pkg::target_e  target_q, target_d;
   soc_map_pkg::target_e  dec_target;

   // Per-target vectors, indexed by target_e
   logic [NT-1:0]  tgt_req_valid;
   logic [NT-1:0]  tgt_req_ready;
   logic [NT-1:0]  tgt_rsp_valid;
   logic [NT-1:0]  tgt_rsp_ready;
   logic [NT-1:0]  tgt_rsp_err;
   bus_pkg::data_t tgt_rsp_rdata [0:NT-1];

   addr_decoder u_decoder (
      .addr_i   (req_addr_i),
      .target_o (dec_target)
   );

   // Payload is broadcast, only valid is steered
   assign mem_write_o       = req_write_i;
   assign mem_addr_o        = req_addr_i;
   assign mem_wdata_o       = req_wdata_i;
   assign mem_wstrb_o       = req_wstrb_i;
   assign apb_bus.req_write = req_write_i;
   assign apb_bus.req_addr  = req_addr_i;
   assign apb_bus.req_wdata = req_wdata_i;
   assign apb_bus.req_wstrb = req_wstrb_i;

   assign tgt_req_ready = {dram_req_ready_i, slm_req_ready_i, clint_req_ready_i,
                           apb_bus.req_ready, rom_req_ready_i};
   assign tgt_rsp_valid = {dram_rsp_valid_i, slm_rsp_valid_i, clint_rsp_valid_i,
                           apb_bus.rsp_valid, rom_rsp_valid_i};
   assign tgt_rsp_err   = {dram_rsp_err_i, slm_rsp_err_i, clint_rsp_err_i,
                           apb_bus.rsp_err, rom_rsp_err_i};
   assign tgt_rsp_rdata = '{rom_rsp_rdata_i, apb_bus.rsp_rdata, clint_rsp_rdata_i,
                            slm_rsp_rdata_i, dram_rsp_rdata_i};

   assign rom_req_valid_o   = tgt_req_valid[soc_map_pkg::TGT_ROM];
   assign apb_bus.req_valid = tgt_req_valid[soc_map_pkg::TGT_APB];
   assign clint_req_valid_o = tgt_req_valid[soc_map_pkg::TGT_CLINT];
   assign slm_req_valid_o   = tgt_req_valid[soc_map_pkg::TGT_SLM];
   assign dram_req_valid_o  = tgt_req_valid[soc_map_pkg::TGT_DRAM];
   assign rom_rsp_ready_o   = tgt_rsp_ready[soc_map_pkg::TGT_ROM];
   assign apb_bus.rsp_ready = tgt_rsp_ready[soc_map_pkg::TGT_APB];
   assign clint_rsp_ready_o = tgt_rsp_ready[soc_map_pkg::TGT_CLINT];
   assign slm_rsp_ready_o   = tgt_rsp_ready[soc_map_pkg::TGT_SLM];
   assign dram_rsp_ready_o  = tgt_rsp_ready[soc_map_pkg::TGT_DRAM];

   // -------------------------------------------------------------------------
   // Routing FSM
   // -------------------------------------------------------------------------
   always_comb begin
      tgt_req_valid = '0;
      tgt_rsp_ready = '0;
      req_ready_o   = 1'b0;
      rsp_valid_o   = 1'b0;
      rsp_rdata_o   = '0;
      rsp_err_o     = 1'b0;
      state_d       = state_q;
      target_d      = target_q;
      case (state_q)
         bus_pkg::ROUTE_IDLE: begin
            if (dec_target == soc_map_pkg::TGT_NONE) begin
               req_ready_o = 1'b1;
            end else begin
               tgt_req_valid[dec_target] = req_valid_i;
               req_ready_o               = tgt_req_ready[dec_target];
            end
            if (req_valid_i && req_ready_o) begin
               target_d = dec_target;
               if (dec_target == soc_map_pkg::TGT_NONE) begin
                  state_d = bus_pkg::ROUTE_ERR;
               end else if (dec_target == soc_map_pkg::TGT_APB) begin
                  state_d = bus_pkg::ROUTE_APB;
               end else begin
                  state_d = bus_pkg::ROUTE_MEM;
               end
            end
         end
         bus_pkg::ROUTE_MEM, bus_pkg::ROUTE_APB: begin
            rsp_valid_o             = tgt_rsp_valid[target_q];
            rsp_rdata_o             = tgt_rsp_rdata[target_q];
            rsp_err_o               = tgt_rsp_err[target_q];
            tgt_rsp_ready[target_q] = rsp_ready_i;
            if (rsp_valid_o && rsp_ready_i) begin
               state_d = bus_pkg::ROUTE_IDLE;
            end
         end
         default: begin
            // Decode error, zero data
            rsp_valid_o = 1'b1;
            rsp_err_o   = 1'b1;
            if (rsp_ready_i) begin
               state_d = bus_pkg::ROUTE_IDLE;
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q  <= bus_pkg::ROUTE_IDLE;
         target_q <= soc_map_pkg::TGT_NONE;
      end else begin
         state_q  <= state_d;
         target_q <= target_d;
      end
   end

   a_one_target: assert property (@(posedge clk) disable iff (reset_i)
      $onehot0(tgt_req_valid));

   a_busy_not_ready: assert property (@(posedge clk) disable iff (reset_i)
      (state_q != bus_pkg::ROUTE_IDLE) |-> !req_ready_o);

endmodule

`default_nettype wire

// File: logic/addr_decoder.sv
// -------------------------------------------------------------------------
// Address decoder, maps an address onto one of the five SoC regions
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module addr_decoder (
   input  bus_pkg::addr_t       addr_i,
   output soc_map_pkg::target_e target_o
);

   logic [soc_map_pkg::N_TARGETS-1:0] hit;

   function automatic logic in_region(bus_pkg::addr_t a, logic [63:0] base,
                                      logic [63:0] len);
      return (a >= base) && (a < base + len);
   endfunction

   // Bit order follows target_e
   assign hit[soc_map_pkg::TGT_ROM] =
      in_region(addr_i, soc_map_pkg::ROM_BASE, soc_map_pkg::ROM_LENGTH);
   assign hit[soc_map_pkg::TGT_APB] =
      in_region(addr_i, soc_map_pkg::APB_BASE, soc_map_pkg::APB_LENGTH);
   assign hit[soc_map_pkg::TGT_CLINT] =
      in_region(addr_i, soc_map_pkg::CLINT_BASE, soc_map_pkg::CLINT_LENGTH);
   assign hit[soc_map_pkg::TGT_SLM] =
      in_region(addr_i, soc_map_pkg::SLM_BASE, soc_map_pkg::SLM_LENGTH);
   assign hit[soc_map_pkg::TGT_DRAM] =
      in_region(addr_i, soc_map_pkg::DRAM_BASE, soc_map_pkg::DRAM_LENGTH);

   always_comb begin
      target_o = soc_map_pkg::TGT_NONE;
      for (int i = 0; i < soc_map_pkg::N_TARGETS; i++) begin
         if (hit[i]) begin
            target_o = soc_map_pkg::target_e'(i);
         end
      end
   end

   // Map regions must not overlap
   always_comb begin
      a_no_overlap: assert #0 ($onehot0(hit));
   end

endmodule

`default_nettype wire

// File: logic/mem_bus_if.sv
// -------------------------------------------------------------------------
// Single-beat request/response bus, router to APB bridge
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;

   // Request channel
   logic           req_valid;
   logic           req_ready;
   logic           req_write;
   bus_pkg::addr_t req_addr;
   bus_pkg::data_t req_wdata;
   bus_pkg::strb_t req_wstrb;

   // Response channel
   logic           rsp_valid;
   logic           rsp_ready;
   bus_pkg::data_t rsp_rdata;
   logic           rsp_err;

   modport initiator (
      output req_valid, req_write, req_addr, req_wdata, req_wstrb, rsp_ready,
      input  req_ready, rsp_valid, rsp_rdata, rsp_err
   );

   modport target (
      input  req_valid, req_write, req_addr, req_wdata, req_wstrb, rsp_ready,
      output req_ready, rsp_valid, rsp_rdata, rsp_err
   );

endinterface

`default_nettype wire

// File: logic/bus_pkg.sv
// -------------------------------------------------------------------------
// Bus widths, payload types and FSM state encodings
// -------------------------------------------------------------------------
`default_nettype none

package bus_pkg;

   localparam int unsigned ADDR_WIDTH     = 64;
   localparam int unsigned DATA_WIDTH     = 64;
   localparam int unsigned STRB_WIDTH     = 8;
   localparam int unsigned APB_ADDR_WIDTH = 32;
   localparam int unsigned APB_DATA_WIDTH = 32;

   typedef logic [ADDR_WIDTH-1:0]     addr_t;
   typedef logic [DATA_WIDTH-1:0]     data_t;
   typedef logic [STRB_WIDTH-1:0]     strb_t;
   typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;
   typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;

   // Router, one transaction in flight
   typedef enum logic [1:0] {
      ROUTE_IDLE = 2'd0,
      ROUTE_MEM  = 2'd1,
      ROUTE_APB  = 2'd2,
      ROUTE_ERR  = 2'd3
   } route_state_e;

   // APB sequencer
   typedef enum logic [1:0] {
      APB_IDLE   = 2'd0,
      APB_SETUP  = 2'd1,
      APB_ACCESS = 2'd2,
      APB_RESP   = 2'd3
   } apb_state_e;

endpackage

`default_nettype wire

// File: logic/soc_map_pkg.sv
// -------------------------------------------------------------------------
// SoC address map with the five target regions and the target encoding
// -------------------------------------------------------------------------
`default_nettype none

package soc_map_pkg;

   localparam int unsigned N_TARGETS = 5;

   localparam logic [63:0] ROM_BASE     = 64'h0000_0000_0001_0000;
   localparam logic [63:0] ROM_LENGTH   = 64'h0000_0000_0001_0000;
   localparam logic [63:0] APB_BASE     = 64'h0000_0000_6000_0000;
   localparam logic [63:0] APB_LENGTH   = 64'h0000_0000_1000_0000;
   localparam logic [63:0] CLINT_BASE   = 64'h0000_0000_0200_0000;
   localparam logic [63:0] CLINT_LENGTH = 64'h0000_0000_000C_0000;
   localparam logic [63:0] SLM_BASE     = 64'h0000_0000_0400_0000;
   localparam logic [63:0] SLM_LENGTH   = 64'h0000_0000_0400_0000;
   localparam logic [63:0] DRAM_BASE    = 64'h0000_0000_8000_0000;
   localparam logic [63:0] DRAM_LENGTH  = 64'h0000_0000_2000_0000;

   // Values double as indices into the per-target vectors
   typedef enum logic [2:0] {
      TGT_ROM   = 3'd0,
      TGT_APB   = 3'd1,
      TGT_CLINT = 3'd2,
      TGT_SLM   = 3'd3,
      TGT_DRAM  = 3'd4,
      TGT_NONE  = 3'd5
   } target_e;

endpackage

`default_nettype wire
